// File: dv/soc_top_properties.sv
/*
 * soc_top_properties
 * bus handshake and interrupt request checks, bound into soc_top
 */

`timescale 1ns/10ps

module soc_top_properties #(
	parameter int IRQ_NUM = 3
)
(
	input logic               clk,
	input logic               reset,
	input logic               stb_i,
	input logic               ack_o,
	input logic               ram_stb,
	input logic               timer_stb,
	input logic               irc_stb,
	input logic               ram_ack,
	input logic               timer_ack,
	input logic               irc_ack,
	input logic [IRQ_NUM-1:0] irq_factor,
	input logic               cpu_irq_o
);

	logic mapped_stb;
	logic mapped_ack;
	logic factor_seen;

	assign mapped_stb = ram_stb | timer_stb | irc_stb;
	assign mapped_ack = ram_ack | timer_ack | irc_ack;

	// set by the first interrupt factor after reset
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			factor_seen <= 1'b0;
		else if (|irq_factor)
			factor_seen <= 1'b1;
	end

	ack_needs_stb: assert property (@(posedge clk) disable iff (reset)
		$rose(ack_o) |-> stb_i)
		else $error("bus acknowledge rose without a strobe");

	// slave ack follows the strobe's first sample
	mapped_ack_latency: assert property (@(posedge clk) disable iff (reset)
		$rose(mapped_stb) |=> mapped_ack)
		else $error("mapped strobe not acknowledged in time");

	irq_quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
		!factor_seen |-> !cpu_irq_o)
		else $error("cpu request raised before any interrupt factor");

endmodule

bind soc_top soc_top_properties #(
	.IRQ_NUM (IRQ_NUM)
) u_soc_top_properties (
	.clk        (clk),
	.reset      (reset),
	.stb_i      (stb_i),
	.ack_o      (ack_o),
	.ram_stb    (ram_stb),
	.timer_stb  (timer_stb),
	.irc_stb    (irc_stb),
	.ram_ack    (ram_ack),
	.timer_ack  (timer_ack),
	.irc_ack    (irc_ack),
	.irq_factor (irq_factor),
	.cpu_irq_o  (cpu_irq_o)
);

// File: dv/soc_top_tb.sv
/*
 * soc_top_tb
 * table-driven bus accesses and interrupt stimulus for the peripheral
 * subsystem, with expected values kept by the testbench
 */

`timescale 1ns/10ps

module soc_top_tb
	import soc_pkg::*;
();

	localparam int RAM_ADDR_WIDTH = 8;
	localparam int IRQ_NUM        = 3;

	// byte addresses of the peripheral registers
	localparam logic [31:0] IRC_CTRL    = 32'hF000_0000;
	localparam logic [31:0] IRC_STATUS  = 32'hF000_0008;
	localparam logic [31:0] IRC_ID      = 32'hF000_000C;
	localparam logic [31:0] TMR_CTRL    = 32'hF100_0000;
	localparam logic [31:0] TMR_COMPARE = 32'hF100_0004;
	localparam logic [31:0] TMR_STATUS  = 32'hF100_0008;
	localparam logic [31:0] UNMAPPED    = 32'h5000_0000;

	typedef enum logic [2:0] {
		OP_WRITE, OP_READ, OP_WAIT, OP_IRQ_ACK, OP_SET_EXT, OP_CHECK_IRQ
	} op_e;

	typedef struct packed {
		int          test;
		op_e         op;
		logic [31:0] addr;
		bus_data_t   data;
		bus_sel_t    sel;
		bus_data_t   exp;
	} entry_t;

	logic               clk;
	logic               reset;
	bus_addr_t          adr_i;
	bus_data_t          dat_i;
	logic               we_i;
	bus_sel_t           sel_i;
	logic               stb_i;
	bus_data_t          dat_o;
	logic               ack_o;
	logic [IRQ_NUM-2:0] ext_irq_i;
	logic               cpu_irq_o;
	logic               cpu_irq_ack_i;

	entry_t    stim [$];
	logic      stim_ready = 1'b0;
	int        pass_count = 0;
	int        fail_count = 0;
	integer    seed = 41;
	bus_data_t ram_model [4];

	soc_top #(
		.RAM_ADDR_WIDTH (RAM_ADDR_WIDTH),
		.IRQ_NUM        (IRQ_NUM)
	) dut (
		.clk           (clk),
		.reset         (reset),
		.adr_i         (adr_i),
		.dat_i         (dat_i),
		.we_i          (we_i),
		.sel_i         (sel_i),
		.stb_i         (stb_i),
		.dat_o         (dat_o),
		.ack_o         (ack_o),
		.ext_irq_i     (ext_irq_i),
		.cpu_irq_o     (cpu_irq_o),
		.cpu_irq_ack_i (cpu_irq_ack_i)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// watchdog over the whole table
	initial begin
		wait (stim_ready);
		repeat (stim.size() * 64) @(posedge clk);
		$display("timeout: the test table did not finish within %0d cycles", stim.size() * 64);
		$display("TEST FAILED");
		$finish;
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------

	function automatic bus_data_t merge_lanes(input bus_data_t old_word,
		input bus_data_t new_word, input bus_sel_t sel);
		bus_data_t result;
		result = old_word;
		for (int lane = 0; lane < 4; lane++) begin
			if (sel[lane])
				result[lane*8 +: 8] = new_word[lane*8 +: 8];
		end
		return result;
	endfunction

	function automatic string test_name(input int test);
		case (test)
			1:       return "ram read-back";
			2:       return "unmapped address";
			3:       return "timer registers";
			4:       return "timer interrupt";
			default: return "priority and masking";
		endcase
	endfunction

	task automatic add_entry(input int test, input op_e op, input logic [31:0] addr,
		input bus_data_t data, input bus_sel_t sel, input bus_data_t exp);
		entry_t e;
		e.test = test;
		e.op   = op;
		e.addr = addr;
		e.data = data;
		e.sel  = sel;
		e.exp  = exp;
		stim.push_back(e);
	endtask

	task automatic check_data(input int idx, input bus_data_t expected, input bus_data_t actual);
		if (actual !== expected) begin
			$display("Mismatch at %0d ns: entry %0d read data expected %h, got %h",
				$time, idx, expected, actual);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_irq(input int idx, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Mismatch at %0d ns: entry %0d cpu_irq_o expected %b, got %b",
				$time, idx, expected, actual);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	// one access with the strobe held until ack and then dropped for a cycle
	task automatic bus_access(input logic [31:0] addr, input bus_data_t wdata,
		input logic write, input bus_sel_t sel, output bus_data_t rdata);
		int waited;
		waited = 0;
		rdata  = '0;
		@(posedge clk);
		#1;
		adr_i = addr[31:2];
		dat_i = wdata;
		we_i  = write;
		sel_i = sel;
		stb_i = 1'b1;
		@(negedge clk);
		while (!ack_o && waited < 16) begin
			@(negedge clk);
			waited++;
		end
		if (ack_o) begin
			rdata = dat_o;
		end else begin
			$display("no acknowledge from address %h after %0d cycles", addr, waited);
			fail_count++;
		end
		@(posedge clk);
		#1;
		stb_i = 1'b0;
		we_i  = 1'b0;
	endtask

	task automatic pulse_irq_ack();
		@(posedge clk);
		#1;
		cpu_irq_ack_i = 1'b1;
		@(posedge clk);
		#1;
		cpu_irq_ack_i = 1'b0;
	endtask

	task automatic run_entry(input int idx, input entry_t e);
		bus_data_t rd;
		case (e.op)
			OP_WRITE: bus_access(e.addr, e.data, 1'b1, e.sel, rd);
			OP_READ: begin
				bus_access(e.addr, '0, 1'b0, e.sel, rd);
				check_data(idx, e.exp, rd);
			end
			OP_WAIT:    repeat (e.data) @(posedge clk);
			OP_IRQ_ACK: pulse_irq_ack();
			OP_SET_EXT: begin
				@(posedge clk);
				#1;
				ext_irq_i = e.data[IRQ_NUM-2:0];
			end
			OP_CHECK_IRQ: begin
				@(negedge clk);
				check_irq(idx, e.exp[0], cpu_irq_o);
			end
			default: ;
		endcase
	endtask

	task automatic report_test(input int test, input int fails_before, input int checks_before);
		int fails;
		int checks;
		fails  = fail_count - fails_before;
		checks = pass_count + fail_count - checks_before;
		$display("test %0d %s: %s, %0d checks", test, test_name(test),
			(fails == 0) ? "ok" : "failed", checks);
	endtask

	// ----------------------------------------------------------------------
	// stimulus table
	// ----------------------------------------------------------------------

	task automatic build_table();
		bus_data_t word;
		for (int i = 0; i < 4; i++) begin
			word         = $random(seed);
			ram_model[i] = word;
			add_entry(1, OP_WRITE, 32'(i * 4), word, 4'hF, '0);
		end
		for (int i = 0; i < 4; i++)
			add_entry(1, OP_READ, 32'(i * 4), '0, 4'hF, ram_model[i]);
		word         = $random(seed);
		ram_model[2] = merge_lanes(ram_model[2], word, 4'b0101);
		add_entry(1, OP_WRITE, 32'h8, word, 4'b0101, '0);
		add_entry(1, OP_READ, 32'h8, '0, 4'hF, ram_model[2]);
		// one word past the end lands on word 0
		add_entry(1, OP_READ, 32'h400, '0, 4'hF, ram_model[0]);

		add_entry(2, OP_WRITE, UNMAPPED, ~ram_model[0], 4'hF, '0);
		add_entry(2, OP_READ, UNMAPPED, '0, 4'hF, '0);
		add_entry(2, OP_READ, 32'h0, '0, 4'hF, ram_model[0]);

		add_entry(3, OP_WRITE, TMR_COMPARE, 32'h1234_5678, 4'hF, '0);
		add_entry(3, OP_READ, TMR_COMPARE, '0, 4'hF, 32'h1234_5678);
		add_entry(3, OP_READ, TMR_STATUS, '0, 4'hF, '0);
		add_entry(3, OP_READ, TMR_STATUS, '0, 4'hF, '0);

		// timer stopped again before its second match
		add_entry(4, OP_WRITE, TMR_COMPARE, 32'd20, 4'hF, '0);
		add_entry(4, OP_WRITE, IRC_CTRL, 32'h1, 4'hF, '0);
		add_entry(4, OP_WRITE, TMR_CTRL, 32'h1, 4'hF, '0);
		add_entry(4, OP_WAIT, '0, 32'd30, 4'h0, '0);
		add_entry(4, OP_WRITE, TMR_CTRL, 32'h0, 4'hF, '0);
		add_entry(4, OP_CHECK_IRQ, '0, '0, 4'h0, 32'h1);
		add_entry(4, OP_READ, IRC_STATUS, '0, 4'hF, 32'h1);
		add_entry(4, OP_IRQ_ACK, '0, '0, 4'h0, '0);
		add_entry(4, OP_CHECK_IRQ, '0, '0, 4'h0, 32'h0);
		add_entry(4, OP_READ, IRC_ID, '0, 4'hF, 32'h0);

		add_entry(5, OP_WRITE, IRC_CTRL, 32'h3, 4'hF, '0);
		add_entry(5, OP_SET_EXT, '0, 32'h3, 4'h0, '0);
		add_entry(5, OP_SET_EXT, '0, 32'h0, 4'h0, '0);
		add_entry(5, OP_CHECK_IRQ, '0, '0, 4'h0, 32'h1);
		add_entry(5, OP_IRQ_ACK, '0, '0, 4'h0, '0);
		add_entry(5, OP_CHECK_IRQ, '0, '0, 4'h0, 32'h0);
		add_entry(5, OP_READ, IRC_ID, '0, 4'hF, 32'h1);
		add_entry(5, OP_READ, IRC_STATUS, '0, 4'hF, 32'h4);
		add_entry(5, OP_WRITE, IRC_CTRL, 32'h7, 4'hF, '0);
		add_entry(5, OP_CHECK_IRQ, '0, '0, 4'h0, 32'h1);
		add_entry(5, OP_WRITE, IRC_STATUS, 32'h4, 4'hF, '0);
		add_entry(5, OP_CHECK_IRQ, '0, '0, 4'h0, 32'h0);
		add_entry(5, OP_READ, IRC_STATUS, '0, 4'hF, 32'h0);
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------

	initial begin
		int cur_test;
		int fails_before;
		int checks_before;
		reset         = 1'b1;
		adr_i         = '0;
		dat_i         = '0;
		we_i          = 1'b0;
		sel_i         = '0;
		stb_i         = 1'b0;
		ext_irq_i     = '0;
		cpu_irq_ack_i = 1'b0;
		build_table();
		stim_ready = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		cur_test      = stim[0].test;
		fails_before  = 0;
		checks_before = 0;
		foreach (stim[i]) begin
			if (stim[i].test != cur_test) begin
				report_test(cur_test, fails_before, checks_before);
				cur_test      = stim[i].test;
				fails_before  = fail_count;
				checks_before = pass_count + fail_count;
			end
			run_entry(i, stim[i]);
		end
		report_test(cur_test, fails_before, checks_before);

		$display("checks: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: filelist.f
verilog/soc_pkg.sv
verilog/bus_decoder.sv
verilog/scratch_ram.sv
verilog/interval_timer.sv
verilog/irq_ctrl.sv
verilog/soc_top.sv
dv/soc_top_properties.sv
dv/soc_top_tb.sv

// File: run_sim.sh
#!/bin/bash
# build with Verilator, run, and look for the pass message in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module soc_top_tb \
	-Mdir obj_dir -o soc_top_tb_sim > build.log 2>&1 \
	&& ./obj_dir/soc_top_tb_sim > sim.log 2>&1 \
	&& grep -q "TEST PASSED" sim.log \
	&& echo "simulation passed, see sim.log" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: verilog/bus_decoder.sv
/*
 * bus_decoder
 * steers the master strobe to one slave by the top address byte and
 * returns that slave's read data and acknowledge to the master
 */

`timescale 1ns/10ps

module bus_decoder
	import soc_pkg::*;
(
	input  bus_addr_t adr_i,
	input  logic      stb_i,

	output logic      ram_stb_o,
	output logic      timer_stb_o,
	output logic      irc_stb_o,

	input  bus_data_t ram_dat_i,
	input  bus_data_t timer_dat_i,
	input  bus_data_t irc_dat_i,
	input  logic      ram_ack_i,
	input  logic      timer_ack_i,
	input  logic      irc_ack_i,

	output bus_data_t dat_o,
	output logic      ack_o
);

	region_e region;

	// classify the top byte, anything unlisted is unmapped
	always_comb begin
		case (adr_i[31:24])
			8'h00:   region = REGION_RAM;
			8'hF0:   region = REGION_IRC;
			8'hF1:   region = REGION_TIMER;
			default: region = REGION_NONE;
		endcase
	end

	// ----------------------------------------------------------------------
	// strobe routing and return mux
	// ----------------------------------------------------------------------

	always_comb begin
		ram_stb_o   = 1'b0;
		timer_stb_o = 1'b0;
		irc_stb_o   = 1'b0;

		case (region)
			REGION_RAM: begin
				ram_stb_o = stb_i;
				dat_o     = ram_dat_i;
				ack_o     = ram_ack_i;
			end
			REGION_IRC: begin
				irc_stb_o = stb_i;
				dat_o     = irc_dat_i;
				ack_o     = irc_ack_i;
			end
			REGION_TIMER: begin
				timer_stb_o = stb_i;
				dat_o       = timer_dat_i;
				ack_o       = timer_ack_i;
			end
			default: begin
				// unmapped, answer at once with zero
				dat_o = '0;
				ack_o = stb_i;
			end
		endcase
	end

endmodule

// File: verilog/interval_timer.sv
/*
 * interval_timer
 * free-running counter with enable and compare value, pulses irq_o
 * for one cycle on each compare match
 */

`timescale 1ns/10ps

module interval_timer
	import soc_pkg::*;
(
	input  logic      clk,
	input  logic      reset,

	input  bus_addr_t adr_i,
	input  bus_data_t dat_i,
	input  logic      we_i,
	input  logic      stb_i,
	output bus_data_t dat_o,
	output logic      ack_o,

	output logic      irq_o
);

	// fixed block identification word
	localparam bus_data_t TIMER_ID = 32'h0000_71E1;

	reg_offset_e offset;
	logic        stb_d;
	logic        req;
	logic        enable;
	bus_data_t   compare;
	bus_data_t   counter;

	assign offset = reg_offset_e'(adr_i[3:2]);
	assign req    = stb_i & ~stb_d;

	// ----------------------------------------------------------------------
	// bus registers
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			stb_d   <= 1'b0;
			ack_o   <= 1'b0;
			enable  <= 1'b0;
			compare <= '0;
		end else begin
			stb_d <= stb_i;
			ack_o <= req;
			if (req && we_i) begin
				case (offset)
					REG_CTRL:    enable  <= dat_i[0];
					REG_COMPARE: compare <= dat_i;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			case (offset)
				REG_CTRL:    dat_o <= bus_data_t'(enable);
				REG_COMPARE: dat_o <= compare;
				REG_STATUS:  dat_o <= counter;
				default:     dat_o <= TIMER_ID;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// counter
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			counter <= '0;
			irq_o   <= 1'b0;
		end else begin
			irq_o <= 1'b0;
			if (enable) begin
				if (counter == compare) begin
					// period reached, restart and flag
					counter <= '0;
					irq_o   <= 1'b1;
				end else begin
					counter <= counter + 1'b1;
				end
			end
		end
	end

endmodule

// File: verilog/irq_ctrl.sv
/*
 * irq_ctrl
 * latches interrupt factors into pending bits, masks them into one
 * level request toward the CPU and records the acknowledged factor
 */

`timescale 1ns/10ps

module irq_ctrl
	import soc_pkg::*;
#(
	parameter int IRQ_NUM = 3
)
(
	input  logic               clk,
	input  logic               reset,

	input  logic [IRQ_NUM-1:0] factor_i,

	input  bus_addr_t          adr_i,
	input  bus_data_t          dat_i,
	input  logic               we_i,
	input  logic               stb_i,
	output bus_data_t          dat_o,
	output logic               ack_o,

	output logic               cpu_irq_o,
	input  logic               cpu_irq_ack_i
);

	// index width, at least one bit
	localparam int ID_WIDTH = (IRQ_NUM > 1) ? $clog2(IRQ_NUM) : 1;

	reg_offset_e         offset;
	logic                stb_d;
	logic                req;
	logic [IRQ_NUM-1:0]  mask;
	logic [IRQ_NUM-1:0]  pending;
	logic [IRQ_NUM-1:0]  active;
	logic [IRQ_NUM-1:0]  wr_clr;
	logic [IRQ_NUM-1:0]  ack_clr;
	logic [IRQ_NUM-1:0]  first_hot;
	logic [ID_WIDTH-1:0] first_idx;
	logic [ID_WIDTH-1:0] last_id;

	assign offset = reg_offset_e'(adr_i[3:2]);
	assign req    = stb_i & ~stb_d;

	assign active    = pending & mask;
	assign cpu_irq_o = |active;

	// ----------------------------------------------------------------------
	// priority, lowest index wins
	// ----------------------------------------------------------------------

	always_comb begin
		first_hot = '0;
		first_idx = '0;
		for (int i = IRQ_NUM - 1; i >= 0; i--) begin
			if (active[i]) begin
				first_hot    = '0;
				first_hot[i] = 1'b1;
				first_idx    = ID_WIDTH'(i);
			end
		end
	end

	assign ack_clr = cpu_irq_ack_i ? first_hot : '0;

	// write one to clear on STATUS
	assign wr_clr = (req && we_i && offset == REG_STATUS) ? dat_i[IRQ_NUM-1:0] : '0;

	// ----------------------------------------------------------------------
	// registers
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			stb_d   <= 1'b0;
			ack_o   <= 1'b0;
			mask    <= '0;
			pending <= '0;
			last_id <= '0;
		end else begin
			stb_d <= stb_i;
			ack_o <= req;
			if (req && we_i && offset == REG_CTRL)
				mask <= dat_i[IRQ_NUM-1:0];
			// a factor still high sets its bit again
			pending <= (pending & ~(wr_clr | ack_clr)) | factor_i;
			if (cpu_irq_ack_i && cpu_irq_o)
				last_id <= first_idx;
		end
	end

	always_ff @(posedge clk) begin
		if (req) begin
			case (offset)
				REG_CTRL:   dat_o <= bus_data_t'(mask);
				REG_STATUS: dat_o <= bus_data_t'(pending);
				REG_ID:     dat_o <= bus_data_t'(last_id);
				default:    dat_o <= '0;
			endcase
		end
	end

endmodule

// File: verilog/scratch_ram.sv
/*
 * scratch_ram
 * word RAM on the system bus with byte lane writes,
 * registered read data and a single-pulse acknowledge
 */

`timescale 1ns/10ps

module scratch_ram
	import soc_pkg::*;
#(
	parameter int RAM_ADDR_WIDTH = 8
)
(
	input  logic      clk,
	input  logic      reset,

	input  bus_addr_t adr_i,
	input  bus_data_t dat_i,
	input  logic      we_i,
	input  bus_sel_t  sel_i,
	input  logic      stb_i,
	output bus_data_t dat_o,
	output logic      ack_o
);

	bus_data_t                 mem [2**RAM_ADDR_WIDTH];
	logic [RAM_ADDR_WIDTH-1:0] word_idx;
	logic                      stb_d;
	logic                      req;

	// upper address bits ignored, so accesses wrap
	assign word_idx = adr_i[RAM_ADDR_WIDTH+1:2];

	// first cycle of a strobe only
	assign req = stb_i & ~stb_d;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			stb_d <= 1'b0;
			ack_o <= 1'b0;
		end else begin
			stb_d <= stb_i;
			ack_o <= req;
		end
	end

	// array and read word
	always_ff @(posedge clk) begin
		if (req) begin
			if (we_i) begin
				for (int lane = 0; lane < 4; lane++) begin
					if (sel_i[lane])
						mem[word_idx][lane*8 +: 8] <= dat_i[lane*8 +: 8];
				end
			end
			dat_o <= mem[word_idx];
		end
	end

endmodule

// File: verilog/soc_pkg.sv
/*
 * soc_pkg
 * shared bus word types plus the address region and register offset
 * encodings used by the decoder and the bus slaves
 */

package soc_pkg;

	// ----------------------------------------------------------------------
	// bus fields
	// ----------------------------------------------------------------------

	// word address, byte offset bits are not carried
	typedef logic [31:2] bus_addr_t;

	typedef logic [31:0] bus_data_t;

	// one enable per byte lane
	typedef logic [3:0]  bus_sel_t;

	// ----------------------------------------------------------------------
	// decode encodings
	// ----------------------------------------------------------------------

	// target slave, compared against address bits 31:24
	typedef enum logic [7:0] {
		REGION_RAM   = 8'h00,
		REGION_IRC   = 8'hF0,
		REGION_TIMER = 8'hF1,
		REGION_NONE  = 8'hFF
	} region_e;

	// register index from word address bits 3:2
	typedef enum logic [1:0] {
		REG_CTRL    = 2'd0,
		REG_COMPARE = 2'd1,
		REG_STATUS  = 2'd2,
		REG_ID      = 2'd3
	} reg_offset_e;

endpackage

// File: verilog/soc_top.sv
/*
 * soc_top
 * bus peripheral subsystem: address decoder, scratch RAM,
 * interval timer and interrupt controller on one strobe/ack bus
 */

`timescale 1ns/10ps

module soc_top
	import soc_pkg::*;
#(
	parameter int RAM_ADDR_WIDTH = 8,
	parameter int IRQ_NUM        = 3
)
(
	input  logic               clk,
	input  logic               reset,

	// master side
	input  bus_addr_t          adr_i,
	input  bus_data_t          dat_i,
	input  logic               we_i,
	input  bus_sel_t           sel_i,
	input  logic               stb_i,
	output bus_data_t          dat_o,
	output logic               ack_o,

	// interrupts
	input  logic [IRQ_NUM-2:0] ext_irq_i,
	output logic               cpu_irq_o,
	input  logic               cpu_irq_ack_i
);

	logic               ram_stb;
	logic               timer_stb;
	logic               irc_stb;
	bus_data_t          ram_dat;
	bus_data_t          timer_dat;
	bus_data_t          irc_dat;
	logic               ram_ack;
	logic               timer_ack;
	logic               irc_ack;
	logic               timer_irq;
	logic [IRQ_NUM-1:0] irq_factor;

	// ----------------------------------------------------------------------
	// interrupt map
	// ----------------------------------------------------------------------

	// factor 0 is the timer, external lines follow
	assign irq_factor = {ext_irq_i, timer_irq};

	// ----------------------------------------------------------------------
	// decoder and slaves
	// ----------------------------------------------------------------------

	bus_decoder u_bus_decoder (
		.adr_i       (adr_i),
		.stb_i       (stb_i),
		.ram_stb_o   (ram_stb),
		.timer_stb_o (timer_stb),
		.irc_stb_o   (irc_stb),
		.ram_dat_i   (ram_dat),
		.timer_dat_i (timer_dat),
		.irc_dat_i   (irc_dat),
		.ram_ack_i   (ram_ack),
		.timer_ack_i (timer_ack),
		.irc_ack_i   (irc_ack),
		.dat_o       (dat_o),
		.ack_o       (ack_o)
	);

	scratch_ram #(
		.RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
	) u_scratch_ram (
		.clk   (clk),
		.reset (reset),
		.adr_i (adr_i),
		.dat_i (dat_i),
		.we_i  (we_i),
		.sel_i (sel_i),
		.stb_i (ram_stb),
		.dat_o (ram_dat),
		.ack_o (ram_ack)
	);

	interval_timer u_interval_timer (
		.clk   (clk),
		.reset (reset),
		.adr_i (adr_i),
		.dat_i (dat_i),
		.we_i  (we_i),
		.stb_i (timer_stb),
		.dat_o (timer_dat),
		.ack_o (timer_ack),
		.irq_o (timer_irq)
	);

	irq_ctrl #(
		.IRQ_NUM (IRQ_NUM)
	) u_irq_ctrl (
		.clk           (clk),
		.reset         (reset),
		.factor_i      (irq_factor),
		.adr_i         (adr_i),
		.dat_i         (dat_i),
		.we_i          (we_i),
		.stb_i         (irc_stb),
		.dat_o         (irc_dat),
		.ack_o         (irc_ack),
		.cpu_irq_o     (cpu_irq_o),
		.cpu_irq_ack_i (cpu_irq_ack_i)
	);

endmodule
